// ==== Makefile ====
# Verilator build for the data chip

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module data_chip
	verilator --lint-only --timing -f list.f --top-module tb_data_chip

sim:
	verilator --binary --timing -f list.f --top-module tb_data_chip -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/tb_data_chip.sv ====
/* Testbench for data_chip. A reference model replays every issued op in order;
   the compare process expects res_valid and mbra_valid two edges after issue.
   Inputs are driven on rising edges, outputs sampled on falling edges. */
`timescale 1ns/1ps
`include "dc_params.svh"
`default_nettype none

module tb_data_chip;

   import dc_uop_pkg::*;
   import dc_status_pkg::*;

   localparam int STREAM_LEN = 48;
   // ops issued over all tests, and the drains that follow them
   localparam int N_ISSUED = 8 + 16 + STREAM_LEN + 6 + 31 + 17;
   localparam int N_DRAINS = 13;
   localparam int OP_BUDGET = 10 + N_ISSUED + 5 * N_DRAINS;   // reset, ops, drain idle

   logic clk;
   logic arst_n;
   logic [`DC_WIDTH-1:0] mi;
   logic mi_valid;
   logic [`DC_WIDTH-1:0] res;
   logic res_valid;
   psw_flags_t psw;
   logic mbra_taken;
   logic mbra_valid;
   logic ir_branch;

   // reference state
   logic [`DC_WIDTH-1:0] m_regs [`DC_NREGS];
   psw_flags_t m_psw;
   logic [`DC_WIDTH-1:0] m_ir;

   // expected pulses, keyed by falling-edge count
   int rq_due[$];
   logic [`DC_WIDTH-1:0] rq_data[$];
   psw_flags_t rq_flags[$];
   int mq_due[$];
   logic mq_taken[$];

   int n_edge = 0;
   int n_checks = 0;
   int n_err = 0;
   int test_err;

   data_chip dut0
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .mi         (mi),
      .mi_valid   (mi_valid),
      .res        (res),
      .res_valid  (res_valid),
      .psw        (psw),
      .mbra_taken (mbra_taken),
      .mbra_valid (mbra_valid),
      .ir_branch  (ir_branch)
   );

   always #2 clk = ~clk;

   task automatic check_data(input string name, input logic [`DC_WIDTH-1:0] exp,
                             input logic [`DC_WIDTH-1:0] act);
      n_checks++;
      if (act !== exp)
      begin
         n_err++;
         $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
      end
   endtask

   task automatic check_flags(input string name, input psw_flags_t exp,
                              input psw_flags_t act);
      n_checks++;
      if (act !== exp)
      begin
         n_err++;
         $display("FAIL %0t %s expected nzvc=%b got nzvc=%b", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      n_checks++;
      if (act !== exp)
      begin
         n_err++;
         $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
      end
   endtask

   function automatic logic sel_ok(input logic [3:0] s);
      return (s <= 4'd7) || (s == SEL_IR_SRC) || (s == SEL_IR_DST);
   endfunction

   function automatic logic [2:0] sel_idx(input logic [3:0] s);
      if (s == SEL_IR_SRC)
         return m_ir[8:6];
      else if (s == SEL_IR_DST)
         return m_ir[2:0];
      return s[2:0];
   endfunction

   function automatic logic cond_ref(input logic [2:0] cc, input psw_flags_t f);
      case (mbr_cond_e'(cc))
         COND_N:  return f.n;
         COND_Z:  return f.z;
         COND_C:  return f.c;
         COND_V:  return f.v;
         COND_NN: return !f.n;
         COND_NZ: return !f.z;
         COND_NC: return !f.c;
         default: return 1'b1;
      endcase
   endfunction

   // PDP-11 conditional branch table
   function automatic logic br_ref(input logic [`DC_WIDTH-1:0] w, input psw_flags_t f);
      logic lt;
      lt = f.n ^ f.v;
      case ({w[15], w[10:8]})
         4'h1: return 1'b1;
         4'h2: return !f.z;
         4'h3: return f.z;
         4'h4: return !lt;
         4'h5: return lt;
         4'h6: return !(f.z || lt);
         4'h7: return f.z || lt;
         4'h8: return !f.n;
         4'h9: return f.n;
         4'ha: return !(f.c || f.z);
         4'hb: return f.c || f.z;
         4'hc: return !f.v;
         4'hd: return f.v;
         4'he: return !f.c;
         4'hf: return f.c;
         default: return 1'b0;
      endcase
   endfunction

   // applies one microinstruction to the model, in issue order
   function automatic void ref_apply(input logic [`DC_WIDTH-1:0] w, output logic has_res,
                                     output logic [`DC_WIDTH-1:0] r, output logic has_mbr,
                                     output logic taken);
      uop_op_e op;
      logic [`DC_WIDTH-1:0] a;
      logic [`DC_WIDTH-1:0] b;
      logic [`DC_WIDTH:0] wide;
      psw_flags_t f;
      op = uop_op_e'(w[15:12]);
      a = sel_ok(w[3:0]) ? m_regs[sel_idx(w[3:0])] : '0;
      b = sel_ok(w[7:4]) ? m_regs[sel_idx(w[7:4])] : '0;
      f = m_psw;
      f.v = 1'b0;
      r = '0;
      case (op)
         OP_MOV:  r = b;
         OP_ADD, OP_ADC:
         begin
            wide = {1'b0, a} + {1'b0, b} + {{`DC_WIDTH{1'b0}}, (op == OP_ADC) && m_psw.c};
            r = wide[`DC_WIDTH-1:0];
            f.c = wide[`DC_WIDTH];
            f.v = (a[15] == b[15]) && (r[15] != a[15]);
         end
         OP_SUB:
         begin
            r = a - b;
            f.c = (a < b);            // borrow
            f.v = (a[15] != b[15]) && (r[15] != a[15]);
         end
         OP_AND:  r = a & b;
         OP_BIC:  r = a & ~b;
         OP_BIS:  r = a | b;
         OP_XOR:  r = a ^ b;
         OP_ASR:
         begin
            r = $signed(b) >>> 1;
            f.c = b[0];
            f.v = r[15] ^ b[0];
         end
         OP_MOVI: r = {8'h00, w[11:4]};
         default: r = '0;
      endcase
      f.n = r[15];
      f.z = (r == '0);
      has_res = (w[15:12] >= 4'd1) && (w[15:12] <= 4'd10);
      has_mbr = (op == OP_MBR);
      taken = cond_ref(w[10:8], m_psw);
      if (has_res && sel_ok(w[3:0]))
         m_regs[sel_idx(w[3:0])] = r;
      if ((w[15:12] >= 4'd1) && (w[15:12] <= 4'd9) && w[UOP_FLAGS_BIT])
         m_psw = f;
      if (op == OP_LDIR)
         m_ir = a;
   endfunction

   function automatic logic [`DC_WIDTH-1:0] alu_word(input logic [3:0] op, input logic fw,
                                                     input logic [3:0] b, input logic [3:0] a);
      return {op, fw, 3'b000, b, a};
   endfunction

   task automatic issue(input logic [`DC_WIDTH-1:0] w);
      logic has_res;
      logic has_mbr;
      logic taken;
      logic [`DC_WIDTH-1:0] r;
      @(posedge clk);
      mi <= w;
      mi_valid <= 1'b1;
      ref_apply(w, has_res, r, has_mbr, taken);
      if (has_res)
      begin
         rq_due.push_back(n_edge + 2);
         rq_data.push_back(r);
         rq_flags.push_back(m_psw);
      end
      if (has_mbr)
      begin
         mq_due.push_back(n_edge + 2);
         mq_taken.push_back(taken);
      end
   endtask

   task automatic drain;
      @(posedge clk);
      mi_valid <= 1'b0;
      while (rq_due.size() != 0 || mq_due.size() != 0)
         @(negedge clk);
      @(negedge clk);
   endtask

   task automatic random_alu(input logic fw);
      issue(alu_word(4'd2 + 4'($urandom % 8), fw, 4'($urandom % 8), 4'($urandom % 8)));
   endtask

   task automatic run_mbrs;
      for (int c = 0; c < 8; c++)
         issue({4'd12, 1'b0, 3'(c), 8'h00});
      drain();
   endtask

   task automatic start_test;
      test_err = n_err;
   endtask

   task automatic finish_test(input string name);
      $display("test %-24s %s (%0d errors)", name,
               (n_err == test_err) ? "ok" : "FAILED", n_err - test_err);
   endtask

   // compare process
   always @(negedge clk)
   begin
      if (arst_n)
      begin
         if (res_valid)
         begin
            if (rq_due.size() == 0 || rq_due[0] != n_edge)
            begin
               n_err++;
               $display("res_valid pulsed at %0t with no result due", $time);
            end
            else
            begin
               check_data("res", rq_data[0], res);
               check_flags("psw", rq_flags[0], psw);
            end
         end
         else if (rq_due.size() != 0 && rq_due[0] == n_edge)
         begin
            n_err++;
            $display("res_valid missing at %0t, two edges after issue", $time);
         end
         if (rq_due.size() != 0 && rq_due[0] == n_edge)
         begin
            void'(rq_due.pop_front());
            void'(rq_data.pop_front());
            void'(rq_flags.pop_front());
         end
         if (mbra_valid)
         begin
            if (mq_due.size() == 0 || mq_due[0] != n_edge)
            begin
               n_err++;
               $display("mbra_valid pulsed at %0t with no branch test due", $time);
            end
            else
               check_bit("mbra_taken", mq_taken[0], mbra_taken);
         end
         else if (mq_due.size() != 0 && mq_due[0] == n_edge)
         begin
            n_err++;
            $display("mbra_valid missing at %0t, two edges after issue", $time);
         end
         if (mq_due.size() != 0 && mq_due[0] == n_edge)
         begin
            void'(mq_due.pop_front());
            void'(mq_taken.pop_front());
         end
      end
      n_edge++;
   end

   initial
   begin
      #((OP_BUDGET + 50) * 4);
      $display("watchdog: the run timed out before all tests finished");
      $display("Test failed");
      $finish;
   end

   initial
   begin
      logic [`DC_WIDTH-1:0] target;
      psw_flags_t psw_before;
      clk = 1'b0;
      arst_n = 1'b0;
      mi = '0;
      mi_valid = 1'b0;
      void'($urandom(32'ha6d5_c83e));
      for (int i = 0; i < `DC_NREGS; i++)
         m_regs[i] = `DC_REG_INIT;
      m_psw = '0;
      m_ir = '0;
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);

      start_test();
      check_bit("res_valid", 1'b0, res_valid);
      check_bit("mbra_valid", 1'b0, mbra_valid);
      check_flags("psw", '0, psw);
      for (int i = 0; i < 8; i++)
         issue(alu_word(4'd1, 1'b1, 4'(i), 4'(i)));
      drain();
      finish_test("reset state");

      start_test();
      for (int i = 0; i < 8; i++)
         issue({4'd10, 8'($urandom), 4'(i)});
      for (int i = 0; i < 8; i++)
         issue(alu_word(4'd1, 1'b1, 4'(i), 4'((i + 3) % 8)));
      drain();
      finish_test("literals and moves");

      start_test();
      for (int i = 0; i < STREAM_LEN; i++)
         random_alu(1'b1);
      drain();
      finish_test("random arithmetic");

      start_test();
      psw_before = m_psw;
      for (int i = 0; i < 6; i++)
         random_alu(1'b0);
      drain();
      check_flags("psw", psw_before, psw);
      finish_test("flags kept");

      start_test();
      issue({4'd10, 8'h00, 4'd0});
      issue(alu_word(4'd1, 1'b1, 4'd0, 4'd1));       // Z set
      run_mbrs();
      issue({4'd10, 8'h01, 4'd0});
      issue({4'd10, 8'h02, 4'd1});
      issue(alu_word(4'd4, 1'b1, 4'd1, 4'd0));       // 1 - 2, N and C set
      run_mbrs();
      issue({4'd10, 8'h01, 4'd2});
      issue(alu_word(4'd9, 1'b1, 4'd2, 4'd3));       // Z, C and V set
      run_mbrs();
      finish_test("microcode branch");

      start_test();
      target = {1'($urandom), 4'b0000, 3'($urandom), 8'($urandom)};
      issue({4'd10, target[15:8], 4'd6});
      for (int i = 0; i < 8; i++)
         issue(alu_word(4'd2, 1'b0, 4'd6, 4'd6));    // shift left by doubling
      issue({4'd10, target[7:0], 4'd5});
      issue(alu_word(4'd7, 1'b0, 4'd5, 4'd6));
      issue({4'd11, 8'h00, 4'd6});                   // LDIR from r6
      drain();
      for (int i = 0; i < 4; i++)
      begin
         random_alu(1'b1);
         drain();
         check_bit("ir_branch", br_ref(m_ir, m_psw), ir_branch);
      end
      issue(alu_word(4'd8, 1'b1, SEL_IR_SRC, SEL_IR_DST));
      drain();
      finish_test("IR branch and selects");

      $display("checks %0d, errors %0d", n_checks, n_err);
      if (n_err == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+src
src/dc_uop_pkg.sv
src/dc_status_pkg.sv
src/micro_decode.sv
src/reg_file.sv
src/alu_lookahead.sv
src/psw_branch.sv
src/data_chip.sv
bench/tb_data_chip.sv

// ==== src/alu_lookahead.sv ====
/* ALU with carry look-ahead inside 4-bit groups, rippling between groups.
   DC_WIDTH must be a multiple of 4. alu_out and new_flags are combinational;
   res and res_valid are registered for opcodes MOV..MOVI. */
`timescale 1ns/1ps
`include "dc_params.svh"
`default_nettype none

module alu_lookahead
(
   input  wire                          clk,
   input  wire                          arst_n,
   input  wire                          valid,
   input  wire dc_uop_pkg::uop_op_e     op,
   input  wire [7:0]                    imm,
   input  wire [`DC_WIDTH-1:0]          op_a,
   input  wire [`DC_WIDTH-1:0]          op_b,
   input  wire                          carry_in,
   output logic [`DC_WIDTH-1:0]         alu_out,
   output dc_status_pkg::psw_flags_t    new_flags,
   output logic [`DC_WIDTH-1:0]         res,
   output logic                         res_valid
);

   import dc_uop_pkg::*;

   logic [`DC_WIDTH-1:0] bm;       // B, inverted for subtract
   logic [`DC_WIDTH-1:0] g;        // generate
   logic [`DC_WIDTH-1:0] p;        // propagate
   logic [`DC_WIDTH:0]   c;        // carry into each bit, c[W] is carry out
   logic [`DC_WIDTH-1:0] sum;
   logic                 ovf;
   logic                 is_out;   // op produces a result

   assign bm = (op == OP_SUB) ? ~op_b : op_b;
   assign g  = op_a & bm;
   assign p  = op_a ^ bm;

   // subtract adds the missing one of the two's complement here
   assign c[0] = (op == OP_SUB) || ((op == OP_ADC) && carry_in);

   genvar k;
   generate
      for (k = 0; k < `DC_WIDTH; k += 4)
      begin : gen_cla
         assign c[k+1] = g[k]
                       | p[k] & c[k];
         assign c[k+2] = g[k+1]
                       | p[k+1] & g[k]
                       | p[k+1] & p[k] & c[k];
         assign c[k+3] = g[k+2]
                       | p[k+2] & g[k+1]
                       | p[k+2] & p[k+1] & g[k]
                       | p[k+2] & p[k+1] & p[k] & c[k];
         assign c[k+4] = g[k+3]
                       | p[k+3] & g[k+2]
                       | p[k+3] & p[k+2] & g[k+1]
                       | p[k+3] & p[k+2] & p[k+1] & g[k]
                       | p[k+3] & p[k+2] & p[k+1] & p[k] & c[k];
      end
   endgenerate

   assign sum = p ^ c[`DC_WIDTH-1:0];
   assign ovf = c[`DC_WIDTH] ^ c[`DC_WIDTH-1];

   always_comb
   begin
      case (op)
         OP_MOV:                 alu_out = op_b;
         OP_ADD, OP_ADC, OP_SUB: alu_out = sum;
         OP_AND:                 alu_out = op_a & op_b;
         OP_BIC:                 alu_out = op_a & ~op_b;
         OP_BIS:                 alu_out = op_a | op_b;
         OP_XOR:                 alu_out = op_a ^ op_b;
         OP_ASR:                 alu_out = {op_b[`DC_WIDTH-1], op_b[`DC_WIDTH-1:1]};
         OP_MOVI:                alu_out = {{(`DC_WIDTH-8){1'b0}}, imm};
         default:                alu_out = '0;
      endcase
   end

   // defaults cover the logic ops and MOV: V cleared, C kept
   always_comb
   begin
      new_flags.n = alu_out[`DC_WIDTH-1];
      new_flags.z = (alu_out == '0);
      new_flags.v = 1'b0;
      new_flags.c = carry_in;
      case (op)
         OP_ADD, OP_ADC:
         begin
            new_flags.c = c[`DC_WIDTH];
            new_flags.v = ovf;
         end
         OP_SUB:
         begin
            new_flags.c = ~c[`DC_WIDTH];   // borrow
            new_flags.v = ovf;
         end
         OP_ASR:
         begin
            new_flags.c = op_b[0];
            new_flags.v = alu_out[`DC_WIDTH-1] ^ op_b[0];
         end
         default:
         begin
            new_flags.v = 1'b0;
         end
      endcase
   end

   assign is_out = (op >= OP_MOV) && (op <= OP_MOVI);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         res_valid <= 1'b0;
         res       <= '0;
      end
      else
      begin
         res_valid <= valid && is_out;
         if (valid && is_out)
            res <= alu_out;
      end
   end

endmodule

`default_nettype wire

// ==== src/data_chip.sv ====
/* Data chip top. One microinstruction per cycle on mi_valid, no
   back-pressure; res_valid and mbra_valid follow two clock edges later. */
`timescale 1ns/1ps
`include "dc_params.svh"
`default_nettype none

module data_chip
(
   input  wire                         clk,
   input  wire                         arst_n,
   input  wire [`DC_WIDTH-1:0]         mi,
   input  wire                         mi_valid,
   output logic [`DC_WIDTH-1:0]        res,
   output logic                        res_valid,
   output dc_status_pkg::psw_flags_t   psw,
   output logic                        mbra_taken,
   output logic                        mbra_valid,
   output logic                        ir_branch
);

   import dc_uop_pkg::*;
   import dc_status_pkg::*;

   logic [`DC_RA_W-1:0]   rd_addr_a;
   logic [`DC_RA_W-1:0]   rd_addr_b;
   logic                  rd_a_zero;
   logic                  rd_b_zero;
   logic                  s1_valid;
   uop_op_e               s1_op;
   logic                  s1_flags_we;
   logic                  s1_wr_en;
   logic [`DC_RA_W-1:0]   s1_wr_addr;
   logic [7:0]            s1_imm;
   mbr_cond_e             s1_cond;
   logic [`DC_WIDTH-1:0]  ir;
   logic [`DC_WIDTH-1:0]  op_a;
   logic [`DC_WIDTH-1:0]  op_b;
   logic [`DC_WIDTH-1:0]  alu_out;
   psw_flags_t            new_flags;

   micro_decode u_decode
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .mi          (mi),
      .mi_valid    (mi_valid),
      .op_a        (op_a),
      .wb_valid    (s1_valid),
      .rd_addr_a   (rd_addr_a),
      .rd_addr_b   (rd_addr_b),
      .rd_a_zero   (rd_a_zero),
      .rd_b_zero   (rd_b_zero),
      .s1_valid    (s1_valid),
      .s1_op       (s1_op),
      .s1_flags_we (s1_flags_we),
      .s1_wr_en    (s1_wr_en),
      .s1_wr_addr  (s1_wr_addr),
      .s1_imm      (s1_imm),
      .s1_cond     (s1_cond),
      .ir          (ir)
   );

   reg_file u_regs
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .rd_en     (mi_valid),
      .rd_addr_a (rd_addr_a),
      .rd_addr_b (rd_addr_b),
      .rd_a_zero (rd_a_zero),
      .rd_b_zero (rd_b_zero),
      .wr_en     (s1_wr_en),
      .wr_addr   (s1_wr_addr),
      .wr_data   (alu_out),
      .op_a      (op_a),
      .op_b      (op_b)
   );

   alu_lookahead u_alu
   (
      .clk       (clk),
      .arst_n    (arst_n),
      .valid     (s1_valid),
      .op        (s1_op),
      .imm       (s1_imm),
      .op_a      (op_a),
      .op_b      (op_b),
      .carry_in  (psw.c),        // ADC sees the previous op's carry
      .alu_out   (alu_out),
      .new_flags (new_flags),
      .res       (res),
      .res_valid (res_valid)
   );

   psw_branch u_psw
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .valid      (s1_valid),
      .flags_we   (s1_flags_we),
      .new_flags  (new_flags),
      .op         (s1_op),
      .cond       (s1_cond),
      .ir         (ir),
      .psw        (psw),
      .mbra_taken (mbra_taken),
      .mbra_valid (mbra_valid),
      .ir_branch  (ir_branch)
   );

endmodule

`default_nettype wire

// ==== src/dc_params.svh ====
/* Sizing for the data chip. Field positions in the microinstruction and IR
   are fixed for a 16-bit word, so DC_WIDTH must stay 16 and DC_RA_W 3. */
`ifndef DC_PARAMS_SVH
`define DC_PARAMS_SVH

`default_nettype none

`define DC_WIDTH     16
`define DC_NREGS     8
`define DC_RA_W      3

// general registers come out of reset as all ones
`define DC_REG_INIT  {`DC_WIDTH{1'b1}}

`default_nettype wire

`endif

// ==== src/dc_status_pkg.sv ====
/* Processor status as kept by the data chip. Only the four condition
   codes are modelled; priority, trap and mode bits are not. */
`default_nettype none

package dc_status_pkg;

   typedef struct packed {
      logic n;   // negative
      logic z;   // zero
      logic v;   // signed overflow
      logic c;   // carry, borrow for subtract
   } psw_flags_t;

endpackage

`default_nettype wire

// ==== src/dc_uop_pkg.sv ====
/* Microinstruction layout: opcode in 15..12, flag write in 11, B select in
   7..4, A select in 3..0. MOVI keeps its literal in 11..4, MBR its cond in 10..8. */
`default_nettype none

package dc_uop_pkg;

   typedef enum logic [3:0] {
      OP_NOP  = 4'd0,
      OP_MOV  = 4'd1,
      OP_ADD  = 4'd2,
      OP_ADC  = 4'd3,
      OP_SUB  = 4'd4,
      OP_AND  = 4'd5,
      OP_BIC  = 4'd6,
      OP_BIS  = 4'd7,
      OP_XOR  = 4'd8,
      OP_ASR  = 4'd9,
      OP_MOVI = 4'd10,
      OP_LDIR = 4'd11,
      OP_MBR  = 4'd12       // 13..15 act as nop
   } uop_op_e;

   typedef enum logic [3:0] {
      SEL_R0     = 4'd0,
      SEL_R1     = 4'd1,
      SEL_R2     = 4'd2,
      SEL_R3     = 4'd3,
      SEL_R4     = 4'd4,
      SEL_R5     = 4'd5,
      SEL_R6     = 4'd6,
      SEL_R7     = 4'd7,
      SEL_IR_SRC = 4'd12,   // ir[8:6]
      SEL_IR_DST = 4'd13    // ir[2:0]
   } uop_sel_e;

   typedef enum logic [2:0] {
      COND_N,
      COND_Z,
      COND_C,
      COND_V,
      COND_NN,
      COND_NZ,
      COND_NC,
      COND_ALWAYS
   } mbr_cond_e;

   localparam int UOP_FLAGS_BIT = 11;   // only honoured for opcodes 1..9

endpackage

`default_nettype wire

// ==== src/micro_decode.sv ====
/* Splits the microinstruction, resolves register selects against IR and
   holds the stage-1 controls. IR selects see IR as of the op's own issue,
   so an op using them must trail an LDIR by at least one cycle. */
`timescale 1ns/1ps
`include "dc_params.svh"
`default_nettype none

module micro_decode
(
   input  wire                         clk,
   input  wire                         arst_n,
   input  wire [`DC_WIDTH-1:0]         mi,
   input  wire                         mi_valid,
   input  wire [`DC_WIDTH-1:0]         op_a,
   input  wire                         wb_valid,
   output logic [`DC_RA_W-1:0]         rd_addr_a,
   output logic [`DC_RA_W-1:0]         rd_addr_b,
   output logic                        rd_a_zero,
   output logic                        rd_b_zero,
   output logic                        s1_valid,
   output dc_uop_pkg::uop_op_e         s1_op,
   output logic                        s1_flags_we,
   output logic                        s1_wr_en,
   output logic [`DC_RA_W-1:0]         s1_wr_addr,
   output logic [7:0]                  s1_imm,
   output dc_uop_pkg::mbr_cond_e       s1_cond,
   output logic [`DC_WIDTH-1:0]        ir
);

   import dc_uop_pkg::*;

   uop_op_e  op;
   logic     is_alu;      // opcodes that may write flags
   logic     writes_a;    // opcodes that write the A register

   // msb of the result marks a select that reads zero and writes nothing
   function automatic logic [`DC_RA_W:0] resolve_sel
   (
      input logic [3:0]            sel,
      input logic [`DC_WIDTH-1:0]  ir_q
   );
      logic [`DC_RA_W:0] r;
      r = {1'b1, {`DC_RA_W{1'b0}}};
      if (sel <= SEL_R7)
         r = {1'b0, sel[`DC_RA_W-1:0]};
      else if (sel == SEL_IR_SRC)
         r = {1'b0, ir_q[8:6]};   // source register field
      else if (sel == SEL_IR_DST)
         r = {1'b0, ir_q[2:0]};   // destination register field
      return r;
   endfunction

   assign op = uop_op_e'(mi[15:12]);

   assign {rd_a_zero, rd_addr_a} = resolve_sel(mi[3:0], ir);
   assign {rd_b_zero, rd_addr_b} = resolve_sel(mi[7:4], ir);

   assign is_alu   = (op >= OP_MOV) && (op <= OP_ASR);
   assign writes_a = (op >= OP_MOV) && (op <= OP_MOVI) && !rd_a_zero;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         s1_valid    <= 1'b0;
         s1_op       <= OP_NOP;
         s1_flags_we <= 1'b0;
         s1_wr_en    <= 1'b0;
      end
      else
      begin
         s1_valid    <= mi_valid;
         s1_flags_we <= mi_valid && is_alu && mi[UOP_FLAGS_BIT];
         s1_wr_en    <= mi_valid && writes_a;
         if (mi_valid)
            s1_op <= op;
      end
   end

   // operands for stage 2, read only while s1_valid is up
   always_ff @(posedge clk)
   begin
      if (mi_valid)
      begin
         s1_wr_addr <= rd_addr_a;
         s1_imm     <= mi[11:4];
         s1_cond    <= mbr_cond_e'(mi[10:8]);
      end
   end

   // LDIR lands at the end of its second cycle
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         ir <= '0;
      else if (wb_valid && (s1_op == OP_LDIR))
         ir <= op_a;
   end

endmodule

`default_nettype wire

// ==== src/psw_branch.sv ====
/* PSW register with the microcode branch test and the PDP-11 branch test.
   The microcode test reads the PSW before the MBR op's own cycle ends;
   ir_branch is purely combinational on IR and the PSW. */
`timescale 1ns/1ps
`include "dc_params.svh"
`default_nettype none

module psw_branch
(
   input  wire                         clk,
   input  wire                         arst_n,
   input  wire                         valid,
   input  wire                         flags_we,
   input  wire dc_status_pkg::psw_flags_t new_flags,
   input  wire dc_uop_pkg::uop_op_e    op,
   input  wire dc_uop_pkg::mbr_cond_e  cond,
   input  wire [`DC_WIDTH-1:0]         ir,
   output dc_status_pkg::psw_flags_t   psw,
   output logic                        mbra_taken,
   output logic                        mbra_valid,
   output logic                        ir_branch
);

   import dc_uop_pkg::*;

   logic mbr_en;
   logic cond_true;

   assign mbr_en = valid && (op == OP_MBR);

   always_comb
   begin
      case (cond)
         COND_N:      cond_true = psw.n;
         COND_Z:      cond_true = psw.z;
         COND_C:      cond_true = psw.c;
         COND_V:      cond_true = psw.v;
         COND_NN:     cond_true = ~psw.n;
         COND_NZ:     cond_true = ~psw.z;
         COND_NC:     cond_true = ~psw.c;
         COND_ALWAYS: cond_true = 1'b1;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         psw        <= '0;
         mbra_valid <= 1'b0;
         mbra_taken <= 1'b0;
      end
      else
      begin
         if (valid && flags_we)
            psw <= new_flags;
         mbra_valid <= mbr_en;
         if (mbr_en)
            mbra_taken <= cond_true;   // held until the next MBR
      end
   end

   // PDP-11 conditional branches, keyed on ir[15] and ir[10:8]
   always_comb
   begin
      case ({ir[15], ir[10:8]})
         4'b0000: ir_branch = 1'b0;                            // not a branch
         4'b0001: ir_branch = 1'b1;                            // BR
         4'b0010: ir_branch = ~psw.z;                          // BNE
         4'b0011: ir_branch = psw.z;                           // BEQ
         4'b0100: ir_branch = ~(psw.n ^ psw.v);                // BGE
         4'b0101: ir_branch = psw.n ^ psw.v;                   // BLT
         4'b0110: ir_branch = ~(psw.z | (psw.n ^ psw.v));      // BGT
         4'b0111: ir_branch = psw.z | (psw.n ^ psw.v);         // BLE
         4'b1000: ir_branch = ~psw.n;                          // BPL
         4'b1001: ir_branch = psw.n;                           // BMI
         4'b1010: ir_branch = ~(psw.c | psw.z);                // BHI
         4'b1011: ir_branch = psw.c | psw.z;                   // BLOS
         4'b1100: ir_branch = ~psw.v;                          // BVC
         4'b1101: ir_branch = psw.v;                           // BVS
         4'b1110: ir_branch = ~psw.c;                          // BCC
         default: ir_branch = psw.c;                           // BCS
      endcase
   end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
/* Eight general registers, two read ports latched on rd_en. A write on the
   same edge as a read of that register is forwarded to the read port. */
`timescale 1ns/1ps
`include "dc_params.svh"
`default_nettype none

module reg_file
(
   input  wire                    clk,
   input  wire                    arst_n,
   input  wire                    rd_en,
   input  wire [`DC_RA_W-1:0]     rd_addr_a,
   input  wire [`DC_RA_W-1:0]     rd_addr_b,
   input  wire                    rd_a_zero,
   input  wire                    rd_b_zero,
   input  wire                    wr_en,
   input  wire [`DC_RA_W-1:0]     wr_addr,
   input  wire [`DC_WIDTH-1:0]    wr_data,
   output logic [`DC_WIDTH-1:0]   op_a,
   output logic [`DC_WIDTH-1:0]   op_b
);

   logic [`DC_WIDTH-1:0] regs [`DC_NREGS];
   logic                 hit_a;   // write targets port A register
   logic                 hit_b;

   assign hit_a = wr_en && (wr_addr == rd_addr_a);
   assign hit_b = wr_en && (wr_addr == rd_addr_b);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         for (int i = 0; i < `DC_NREGS; i++)
            regs[i] <= `DC_REG_INIT;
      end
      else if (wr_en)
         regs[wr_addr] <= wr_data;
   end

   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         if (rd_a_zero)
            op_a <= '0;
         else if (hit_a)
            op_a <= wr_data;     // bypass
         else
            op_a <= regs[rd_addr_a];

         if (rd_b_zero)
            op_b <= '0;
         else if (hit_b)
            op_b <= wr_data;
         else
            op_b <= regs[rd_addr_b];
      end
   end

endmodule

`default_nettype wire
